/* design/ranger_pkg.sv */
`default_nettype none

package ranger_pkg;

  // register offsets on the APB.
  localparam logic [3:0] addr_ctrl   = 4'h0;
  localparam logic [3:0] addr_period = 4'h4;
  localparam logic [3:0] addr_result = 4'h8;
  localparam logic [3:0] addr_status = 4'hC;

  // bit positions in CTRL.
  localparam int ctrl_enable = 0;
  localparam int ctrl_shot   = 1;
  localparam int ctrl_irq_en = 2;

  // bit position of the sticky done flag in STATUS.
  localparam int status_done = 0;

  // 200 ms between periodic measurements.
  localparam logic [23:0] period_rst = 24'd200_000;

  // speed of sound at room temperature.
  localparam int sound_cm_per_s = 34000;

  // trigger pulse width in microseconds.
  localparam int trigger_us = 10;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // field order matches the RESULT register layout.
  typedef struct packed {
    logic        no_echo;
    logic        timeout;
    logic [15:0] distance_cm;
  } range_result_t;

endpackage

`default_nettype wire

/* design/trigger_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module trigger_timer #(
  parameter int clk_freq = 50_000_000
) (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        enable,
  input  wire logic [23:0] period_us,
  input  wire logic        shot,
  output logic             trig,
  output logic             arm
);

  // nearest whole number of clocks per microsecond.
  localparam int us_div_raw  = (clk_freq + 500_000) / 1_000_000;
  localparam int us_div      = (us_div_raw < 1) ? 1 : us_div_raw;
  localparam int us_width    = (us_div > 1) ? $clog2(us_div) : 1;
  localparam int pulse_width = $clog2(ranger_pkg::trigger_us + 1);

  logic [us_width-1:0]    us_cnt;
  logic                   us_tick;
  logic [23:0]            period_cnt;
  logic                   period_done;
  logic [pulse_width-1:0] pulse_cnt;
  logic                   start;
  logic                   pulse_end;

  assign us_tick     = (us_cnt == us_width'(us_div - 1));
  assign period_done = enable && us_tick &&
                       ({1'b0, period_cnt} + 25'd1 >= {1'b0, period_us});
  // requests during a pulse are dropped.
  assign start       = !trig && (shot || period_done);
  assign pulse_end   = trig && us_tick &&
                       (pulse_cnt == pulse_width'(ranger_pkg::trigger_us - 1));

  // prescaler restarts with each pulse so the width is exact.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      us_cnt <= '0;
    end else if (start || us_tick) begin
      us_cnt <= '0;
    end else begin
      us_cnt <= us_cnt + 1'b1;
    end
  end

  // held at zero while disabled or pulsing.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      period_cnt <= '0;
    end else if (!enable || trig || start) begin
      period_cnt <= '0;
    end else if (us_tick) begin
      period_cnt <= period_cnt + 24'd1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trig      <= 1'b0;
      pulse_cnt <= '0;
      arm       <= 1'b0;
    end else begin
      arm <= pulse_end;
      if (start) begin
        trig      <= 1'b1;
        pulse_cnt <= '0;
      end else if (pulse_end) begin
        trig <= 1'b0;
      end else if (trig && us_tick) begin
        pulse_cnt <= pulse_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/echo_meter.sv */
`timescale 1ns/100ps
`default_nettype none

module echo_meter #(
  parameter int clk_freq     = 50_000_000,
  parameter int max_range_cm = 400
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 echo,
  input  wire logic                 arm,
  output logic                      result_valid,
  output ranger_pkg::range_result_t result
);

  // clocks of echo high time per centimetre of range, out and back.
  localparam int cm_div     = 2 * clk_freq / ranger_pkg::sound_cm_per_s;
  localparam int cm_width   = (cm_div > 1) ? $clog2(cm_div) : 1;
  localparam int dist_width = $clog2(max_range_cm + 1);

  localparam logic [1:0] st_idle      = 2'd0;
  localparam logic [1:0] st_wait_rise = 2'd1;
  localparam logic [1:0] st_measure   = 2'd2;
  localparam logic [1:0] st_done      = 2'd3;

  logic                  echo_s1;
  logic                  echo_s2;
  logic                  echo_d;
  logic                  rise;
  logic                  fall;
  logic [1:0]            state;
  logic [cm_width-1:0]   pre_cnt;
  logic [dist_width-1:0] cm_cnt;
  logic                  cm_tick;
  logic                  cap;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      echo_s1 <= 1'b0;
      echo_s2 <= 1'b0;
      echo_d  <= 1'b0;
    end else begin
      echo_s1 <= echo;
      echo_s2 <= echo_s1;
      echo_d  <= echo_s2;
    end
  end

  assign rise    = echo_s2 && !echo_d;
  assign fall    = !echo_s2 && echo_d;
  assign cm_tick = (state == st_measure) && !fall && (pre_cnt == cm_width'(cm_div - 1));
  assign cap     = cm_tick && (cm_cnt == dist_width'(max_range_cm - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= st_idle;
      pre_cnt      <= '0;
      cm_cnt       <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= 1'b0;
      case (state)
        st_idle, st_done: begin
          if (arm) begin
            state <= st_wait_rise;
          end
        end
        st_wait_rise: begin
          if (arm) begin
            result_valid <= 1'b1;
          end else if (rise) begin
            state   <= st_measure;
            // rise cycle counts as the first high clock.
            pre_cnt <= cm_width'(1);
            cm_cnt  <= '0;
          end
        end
        default: begin
          if (fall) begin
            result_valid <= 1'b1;
            state        <= st_idle;
          end else if (cap) begin
            result_valid <= 1'b1;
            state        <= st_done;
          end else if (cm_tick) begin
            pre_cnt <= '0;
            cm_cnt  <= cm_cnt + 1'b1;
          end else begin
            pre_cnt <= pre_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_wait_rise && arm) begin
      result <= '{no_echo: 1'b1, timeout: 1'b0, distance_cm: 16'd0};
    end else if (cap) begin
      result <= '{no_echo: 1'b0, timeout: 1'b1, distance_cm: 16'(max_range_cm)};
    end else if (state == st_measure && fall) begin
      result <= '{no_echo: 1'b0, timeout: 1'b0, distance_cm: 16'(cm_cnt)};
    end
  end

endmodule

`default_nettype wire

/* design/ranger_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module ranger_regs (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire ranger_pkg::apb_req_t      apb,
  input  wire logic                      result_valid,
  input  wire ranger_pkg::range_result_t result,
  output logic [31:0]                    prdata,
  output logic                           pready,
  output logic                           pslverr,
  output logic                           enable,
  output logic [23:0]                    period_us,
  output logic                           shot,
  output logic                           irq
);

  logic                      access;
  logic                      addr_hit;
  logic                      wr_en;
  logic                      irq_en;
  logic                      done;
  logic [7:0]                meas_cnt;
  ranger_pkg::range_result_t result_q;

  assign access = apb.psel && apb.penable;

  always_comb begin
    addr_hit = apb.paddr inside {ranger_pkg::addr_ctrl, ranger_pkg::addr_period,
                                 ranger_pkg::addr_result, ranger_pkg::addr_status};
  end

  assign wr_en   = access && apb.pwrite && addr_hit;
  // no wait states.
  assign pready  = 1'b1;
  assign pslverr = access && !addr_hit;
  assign irq     = done && irq_en;

  always_comb begin
    prdata = '0;
    case (apb.paddr)
      ranger_pkg::addr_ctrl: begin
        prdata[ranger_pkg::ctrl_enable] = enable;
        prdata[ranger_pkg::ctrl_irq_en] = irq_en;
      end
      ranger_pkg::addr_period: begin
        prdata[23:0] = period_us;
      end
      ranger_pkg::addr_result: begin
        prdata[17:0] = result_q;
      end
      ranger_pkg::addr_status: begin
        prdata[ranger_pkg::status_done] = done;
        prdata[15:8]                    = meas_cnt;
      end
      default: begin
        prdata = '0;
      end
    endcase
  end

  // shot is a one-clock pulse, never stored.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable    <= 1'b0;
      irq_en    <= 1'b0;
      shot      <= 1'b0;
      period_us <= ranger_pkg::period_rst;
    end else begin
      shot <= 1'b0;
      if (wr_en && apb.paddr == ranger_pkg::addr_ctrl) begin
        enable <= apb.pwdata[ranger_pkg::ctrl_enable];
        irq_en <= apb.pwdata[ranger_pkg::ctrl_irq_en];
        shot   <= apb.pwdata[ranger_pkg::ctrl_shot];
      end
      if (wr_en && apb.paddr == ranger_pkg::addr_period) begin
        period_us <= apb.pwdata[23:0];
      end
    end
  end

  // a new result wins over a clear in the same cycle.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_q <= '0;
      done     <= 1'b0;
      meas_cnt <= '0;
    end else if (result_valid) begin
      result_q <= result;
      done     <= 1'b1;
      meas_cnt <= meas_cnt + 8'd1;
    end else if (wr_en && apb.paddr == ranger_pkg::addr_status &&
                 apb.pwdata[ranger_pkg::status_done]) begin
      done <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/ranger_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ranger_top #(
  parameter int clk_freq     = 50_000_000,
  parameter int max_range_cm = 400
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire ranger_pkg::apb_req_t apb,
  input  wire logic                 echo,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      trig,
  output logic                      irq
);

  logic                      enable;
  logic [23:0]               period_us;
  logic                      shot;
  logic                      arm;
  logic                      result_valid;
  ranger_pkg::range_result_t result;

  ranger_regs u_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .apb          (apb),
    .result_valid (result_valid),
    .result       (result),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .enable       (enable),
    .period_us    (period_us),
    .shot         (shot),
    .irq          (irq)
  );

  trigger_timer #(
    .clk_freq (clk_freq)
  ) u_trigger (
    .clk       (clk),
    .rst_n     (rst_n),
    .enable    (enable),
    .period_us (period_us),
    .shot      (shot),
    .trig      (trig),
    .arm       (arm)
  );

  // arm opens the echo window once the trigger has ended.
  echo_meter #(
    .clk_freq     (clk_freq),
    .max_range_cm (max_range_cm)
  ) u_echo (
    .clk          (clk),
    .rst_n        (rst_n),
    .echo         (echo),
    .arm          (arm),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

/* testbench/ranger_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module ranger_checker #(
  parameter int trig_clocks = 20
) (
  input wire logic                      clk,
  input wire logic                      rst_n,
  input wire logic                      trig,
  input wire logic                      pready,
  input wire logic                      result_valid,
  input wire ranger_pkg::range_result_t result
);

  // read by the testbench at the end of the run.
  int fail_count = 0;

  // 10 us of trigger at two clocks per tick.
  trig_width: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(trig) |-> trig [*trig_clocks] ##1 !trig)
  else begin
    fail_count++;
    $error("trigger pulse is not %0d clocks wide", trig_clocks);
  end

  ready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
  else begin
    fail_count++;
    $error("pready dropped low");
  end

  flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> !(result.timeout && result.no_echo))
  else begin
    fail_count++;
    $error("result has both timeout and no_echo set");
  end

endmodule

bind ranger_top ranger_checker u_checker (
  .clk          (clk),
  .rst_n        (rst_n),
  .trig         (trig),
  .pready       (pready),
  .result_valid (result_valid),
  .result       (result)
);

`default_nettype wire

/* testbench/tb_ranger.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ranger;

  localparam int clk_freq     = 1_700_000;
  localparam int max_range_cm = 40;
  // echo clocks per centimetre of range.
  localparam int clk_per_cm   = 2 * clk_freq / ranger_pkg::sound_cm_per_s;
  localparam int wait_limit   = 20000;
  localparam int echo_delay   = 4;
  localparam logic [31:0] ctrl_shot_irq = 32'h6;
  localparam logic [31:0] ctrl_run_irq  = 32'h5;

  logic                 clk;
  logic                 rst_n;
  ranger_pkg::apb_req_t apb;
  logic                 echo;
  logic [31:0]          prdata;
  logic                 pready;
  logic                 pslverr;
  logic                 trig;
  logic                 irq;

  integer seed;
  int     errors;
  int     checks;
  int     tests;
  int     test_errors;
  logic   aborted;
  logic   echo_on;
  int     fixed_len;
  int     delay_left;
  int     high_left;
  int     trig_count;
  logic   trig_q;
  int     len_q[$];
  ranger_pkg::range_result_t exp_q[$];
  ranger_pkg::range_result_t act_q[$];

  ranger_top #(
    .clk_freq     (clk_freq),
    .max_range_cm (max_range_cm)
  ) UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb     (apb),
    .echo    (echo),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .trig    (trig),
    .irq     (irq)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic ranger_pkg::range_result_t expect_range(input int clocks,
                                                             input bit missing);
    ranger_pkg::range_result_t r;
    int cm;
    r  = '0;
    cm = clocks / clk_per_cm;
    if (missing) begin
      r.no_echo = 1'b1;
    end else if (cm >= max_range_cm) begin
      r.timeout     = 1'b1;
      r.distance_cm = 16'(max_range_cm);
    end else begin
      r.distance_cm = 16'(cm);
    end
    return r;
  endfunction

  function automatic int next_echo_len();
    int len;
    if (fixed_len > 0) begin
      len = fixed_len;
    end else begin
      // 1 to 38 cm.
      len = 150 + int'({$random(seed)} % 3700);
    end
    len_q.push_back(len);
    return len;
  endfunction

  // sensor answers each trigger after a short delay.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trig_q     <= 1'b0;
      delay_left <= 0;
      high_left  <= 0;
      trig_count <= 0;
      echo       <= 1'b0;
    end else begin
      trig_q <= trig;
      if (trig && !trig_q) begin
        trig_count <= trig_count + 1;
      end
      if (trig_q && !trig && echo_on) begin
        delay_left <= echo_delay;
      end else if (delay_left > 0) begin
        delay_left <= delay_left - 1;
        if (delay_left == 1) begin
          echo      <= 1'b1;
          high_left <= next_echo_len();
        end
      end else if (high_left > 0) begin
        high_left <= high_left - 1;
        if (high_left == 1) begin
          echo <= 1'b0;
        end
      end
    end
  end

  task automatic finish_run();
    errors += UUT.u_checker.fail_count;
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout at %0d ns while waiting for %s", $time, what);
    errors++;
    aborted = 1'b1;
    // held here until the test sequence is stopped.
    wait (!aborted);
  endtask

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %0d ns %s: expected 0x%08h, got 0x%08h", $time, name, exp, act);
    end
  endtask

  task automatic compare_result(input string name, input ranger_pkg::range_result_t exp,
                                input ranger_pkg::range_result_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %0d ns %s: expected dist=%0d to=%0b ne=%0b, got dist=%0d to=%0b ne=%0b",
               $time, name, exp.distance_cm, exp.timeout, exp.no_echo,
               act.distance_cm, act.timeout, act.no_echo);
    end
  endtask

  // scoreboard.
  always @(posedge clk) begin
    if (exp_q.size() > 0 && act_q.size() > 0) begin
      compare_result("result", exp_q.pop_front(), act_q.pop_front());
    end
  end

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic err);
    int n;
    @(posedge clk);
    apb <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge clk);
    apb.penable <= 1'b1;
    n = 0;
    @(posedge clk);
    while (!pready && n < 16) begin
      n++;
      @(posedge clk);
    end
    if (!pready) begin
      abort_on_timeout("pready on a write");
    end
    err = pslverr;
    apb <= '0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic err);
    int n;
    @(posedge clk);
    apb <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
    @(posedge clk);
    apb.penable <= 1'b1;
    n = 0;
    @(posedge clk);
    while (!pready && n < 16) begin
      n++;
      @(posedge clk);
    end
    if (!pready) begin
      abort_on_timeout("pready on a read");
    end
    data = prdata;
    err  = pslverr;
    apb <= '0;
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    compare_word("pslverr", 32'd0, {31'd0, err});
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
    logic err;
    apb_read(addr, data, err);
    compare_word("pslverr", 32'd0, {31'd0, err});
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    while (!irq && n < wait_limit) begin
      @(posedge clk);
      n++;
    end
    if (!irq) begin
      abort_on_timeout("irq");
    end
  endtask

  task automatic wait_trig_pulse();
    int n;
    n = 0;
    while (!trig && n < wait_limit) begin
      @(posedge clk);
      n++;
    end
    if (!trig) begin
      abort_on_timeout("trig to rise");
    end
    n = 0;
    while (trig && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (trig) begin
      abort_on_timeout("trig to fall");
    end
  endtask

  task automatic wait_echo_idle();
    int n;
    n = 0;
    while ((echo || high_left > 0 || delay_left > 0) && n < wait_limit) begin
      @(posedge clk);
      n++;
    end
    if (echo || high_left > 0 || delay_left > 0) begin
      abort_on_timeout("echo to end");
    end
  endtask

  // reads RESULT and queues it against the reference.
  task automatic collect_result(input bit missing);
    logic [31:0] rd;
    int len;
    len = 0;
    read_reg(ranger_pkg::addr_result, rd);
    if (!missing) begin
      if (len_q.size() == 0) begin
        errors++;
        $display("no echo pulse was sent for the result read at %0d ns", $time);
      end else begin
        len = len_q.pop_front();
      end
    end
    exp_q.push_back(expect_range(len, missing));
    act_q.push_back(ranger_pkg::range_result_t'(rd[17:0]));
  endtask

  task automatic begin_test();
    test_errors = errors;
  endtask

  task automatic end_test(input string name);
    int n;
    n = 0;
    while ((exp_q.size() > 0 || act_q.size() > 0) && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() > 0 || act_q.size() > 0) begin
      abort_on_timeout("the scoreboard to drain");
    end
    tests++;
    $display("test %-14s %s", name, (errors == test_errors) ? "passed" : "failed");
  endtask

  task automatic test_registers();
    logic [31:0] rd;
    logic        err;
    begin_test();
    read_reg(ranger_pkg::addr_ctrl, rd);
    compare_word("ctrl", 32'd0, rd);
    read_reg(ranger_pkg::addr_period, rd);
    compare_word("period", 32'd200_000, rd);
    read_reg(ranger_pkg::addr_result, rd);
    compare_word("result", 32'd0, rd);
    read_reg(ranger_pkg::addr_status, rd);
    compare_word("status", 32'd0, rd);
    write_reg(ranger_pkg::addr_period, 32'h0012_3456);
    read_reg(ranger_pkg::addr_period, rd);
    compare_word("period", 32'h0012_3456, rd);
    write_reg(ranger_pkg::addr_ctrl, 32'h4);
    read_reg(ranger_pkg::addr_ctrl, rd);
    compare_word("ctrl", 32'h4, rd);
    write_reg(ranger_pkg::addr_ctrl, 32'h0);
    // 0x10 wraps to CTRL on a 4-bit bus, so use a hole in the map.
    apb_read(4'hE, rd, err);
    compare_word("pslverr", 32'd1, {31'd0, err});
    apb_write(4'hE, 32'hFFFF_FFFF, err);
    compare_word("pslverr", 32'd1, {31'd0, err});
    read_reg(ranger_pkg::addr_period, rd);
    compare_word("period", 32'h0012_3456, rd);
    end_test("registers");
  endtask

  task automatic test_single_shot();
    logic [31:0] rd;
    logic [7:0]  cnt;
    int          trigs;
    int          i;
    begin_test();
    fixed_len = 0;
    for (i = 0; i < 4; i++) begin
      read_reg(ranger_pkg::addr_status, rd);
      cnt   = rd[15:8];
      trigs = trig_count;
      write_reg(ranger_pkg::addr_status, 32'd1);
      write_reg(ranger_pkg::addr_ctrl, ctrl_shot_irq);
      // the shot bit is write-only.
      read_reg(ranger_pkg::addr_ctrl, rd);
      compare_word("ctrl", 32'h4, rd);
      wait_irq();
      collect_result(1'b0);
      compare_word("trig count", 32'(trigs + 1), 32'(trig_count));
      read_reg(ranger_pkg::addr_status, rd);
      compare_word("status", {16'd0, cnt + 8'd1, 7'd0, 1'b1}, rd);
    end
    end_test("single shot");
  endtask

  task automatic test_timeout();
    logic [31:0] rd;
    begin_test();
    fixed_len = 46 * clk_per_cm;
    write_reg(ranger_pkg::addr_status, 32'd1);
    write_reg(ranger_pkg::addr_ctrl, ctrl_shot_irq);
    wait_irq();
    collect_result(1'b0);
    // the tail of the echo must be ignored.
    wait_echo_idle();
    read_reg(ranger_pkg::addr_result, rd);
    compare_word("result", {14'd0, 2'b01, 16'(max_range_cm)}, rd);
    fixed_len = 0;
    end_test("timeout");
  endtask

  task automatic test_periodic();
    logic [31:0] rd;
    logic [7:0]  cnt;
    int          trigs;
    int          i;
    begin_test();
    fixed_len = 0;
    write_reg(ranger_pkg::addr_period, 32'd2500);
    write_reg(ranger_pkg::addr_status, 32'd1);
    read_reg(ranger_pkg::addr_status, rd);
    cnt   = rd[15:8];
    trigs = trig_count;
    write_reg(ranger_pkg::addr_ctrl, ctrl_run_irq);
    for (i = 0; i < 3; i++) begin
      wait_irq();
      collect_result(1'b0);
      write_reg(ranger_pkg::addr_status, 32'd1);
      @(posedge clk);
      compare_word("irq", 32'd0, {31'd0, irq});
    end
    write_reg(ranger_pkg::addr_ctrl, 32'd0);
    compare_word("trig count", 32'(trigs + 3), 32'(trig_count));
    read_reg(ranger_pkg::addr_status, rd);
    compare_word("status", {16'd0, cnt + 8'd3, 8'd0}, rd);
    end_test("periodic");
  endtask

  task automatic test_no_echo();
    logic [31:0] rd;
    logic [7:0]  cnt;
    begin_test();
    echo_on = 1'b0;
    write_reg(ranger_pkg::addr_status, 32'd1);
    read_reg(ranger_pkg::addr_status, rd);
    cnt = rd[15:8];
    write_reg(ranger_pkg::addr_ctrl, ctrl_shot_irq);
    wait_trig_pulse();
    repeat (10) @(posedge clk);
    // meter is armed but has nothing to report yet.
    read_reg(ranger_pkg::addr_status, rd);
    compare_word("status", {16'd0, cnt, 8'd0}, rd);
    write_reg(ranger_pkg::addr_ctrl, ctrl_shot_irq);
    wait_irq();
    collect_result(1'b1);
    read_reg(ranger_pkg::addr_status, rd);
    compare_word("status", {16'd0, cnt + 8'd1, 7'd0, 1'b1}, rd);
    end_test("no echo");
  endtask

  task automatic run_tests();
    test_registers();
    test_single_shot();
    test_timeout();
    test_periodic();
    // leaves the meter armed, so it runs last.
    test_no_echo();
  endtask

  initial begin
    seed        = 32'hc0f1;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    test_errors = 0;
    aborted     = 1'b0;
    echo_on     = 1'b1;
    fixed_len   = 0;
    apb         = '0;
    echo        = 1'b0;
    rst_n       = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    fork
      run_tests();
      wait (aborted);
    join_any
    disable fork;
    finish_run();
  end

endmodule

`default_nettype wire

/* list.f */
design/ranger_pkg.sv
design/trigger_timer.sv
design/echo_meter.sv
design/ranger_regs.sv
design/ranger_top.sv
testbench/ranger_checker.sv
testbench/tb_ranger.sv

/* Bender.yml */
package:
  name: ranger

sources:
  - design/ranger_pkg.sv
  - design/trigger_timer.sv
  - design/echo_meter.sv
  - design/ranger_regs.sv
  - design/ranger_top.sv
  - target: test
    files:
      - testbench/ranger_checker.sv
      - testbench/tb_ranger.sv
